// ==== design/tiling_pkg.sv ====
`default_nettype none

package tiling_pkg;

    //////////////////////////////
    // Data widths
    //////////////////////////////

    // One feature-map pixel
    typedef logic [15:0] pixel_t;

    // DDR address in pixels, not bytes
    typedef logic [31:0] ddr_addr_t;

    // log2 of a frame dimension
    typedef logic [3:0] pow2_t;

    // Pixel count of one image row
    typedef logic [15:0] row_len_t;

    //////////////////////////////
    // Defaults
    //////////////////////////////

    // Matches the column count of the conv core
    localparam int BUF_NUM_DEFAULT = 4;

endpackage

`default_nettype wire

// ==== design/pixel_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pixel_stream_if import tiling_pkg::*; ();

    // Driven by the source
    logic   valid;
    pixel_t data;
    logic   last;

    // Driven by the sink
    logic   ready;

    modport source (
        output valid, data, last,
        input  ready
    );

    modport sink (
        input  valid, data, last,
        output ready
    );

endinterface

`default_nettype wire

// ==== design/column_line_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module column_line_buf import tiling_pkg::*; #(
    parameter int BUF_DEPTH_2POW = 6
) (
    input  wire                      clk,
    input  wire                      wr_en,
    input  wire [BUF_DEPTH_2POW-1:0] wr_addr,
    input  wire pixel_t              wr_data,
    input  wire [BUF_DEPTH_2POW-1:0] rd_addr,
    output pixel_t                   rd_data
);

    // One image row for one conv column
    pixel_t mem [2**BUF_DEPTH_2POW];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read with data one cycle after rd_addr
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== design/load_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_fifo import tiling_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             load_valid,
    input  wire pixel_t     load_data,
    input  wire             load_last,
    output logic            load_ready,
    pixel_stream_if.source  out
);

    localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int PTR_W  = ADDR_W + 1;

    pixel_t           mem_data [FIFO_DEPTH];
    logic             mem_last [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    // Step the index, flip the wrap bit at the end of storage
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] n;
        if (p[ADDR_W-1:0] == ADDR_W'(FIFO_DEPTH - 1)) begin
            n = {~p[ADDR_W], {ADDR_W{1'b0}}};
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    // Same index, different wrap bit means full
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign push  = load_valid && load_ready;
    assign pop   = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= load_data;
            mem_last[wr_ptr[ADDR_W-1:0]] <= load_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
        end
    end

    assign load_ready = !full;
    assign out.valid  = !empty;
    assign out.data   = mem_data[rd_ptr[ADDR_W-1:0]];
    assign out.last   = mem_last[rd_ptr[ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== design/load_req_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_req_gen import tiling_pkg::*; #(
    parameter int BUF_NUM = BUF_NUM_DEFAULT
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        start,
    input  wire pow2_t ix_2pow,
    input  wire pow2_t iy_2pow,
    input  wire pow2_t nif_2pow,
    input  wire        load_continue,
    input  wire        req_ready,
    output logic       req_valid,
    output ddr_addr_t  req_addr,
    output row_len_t   req_len,
    output logic       busy
);

    localparam int TILE_W = $clog2(BUF_NUM);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_CONT
    } state_t;

    state_t            state;
    pow2_t             ix_q;
    pow2_t             iy_q;
    pow2_t             nif_q;
    logic [TILE_W-1:0] tile_row;
    ddr_addr_t         frame_row;
    ddr_addr_t         frame_rows;
    logic              req_fire;
    logic              tile_end;

    // Rows in the frame over all channels
    assign frame_rows = ddr_addr_t'(1) << ({1'b0, nif_q} + {1'b0, iy_q});
    assign req_fire   = req_valid && req_ready;
    assign tile_end   = (tile_row == TILE_W'(BUF_NUM - 1));

    // Frame config held for the whole frame
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            ix_q  <= ix_2pow;
            iy_q  <= iy_2pow;
            nif_q <= nif_2pow;
        end
    end

    //////////////////////////////
    // Row sequencing FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            tile_row  <= '0;
            frame_row <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= ISSUE;
                        tile_row  <= '0;
                        frame_row <= '0;
                    end
                end
                ISSUE: begin
                    if (req_fire) begin
                        frame_row <= frame_row + 1'b1;
                        if (tile_end) begin
                            tile_row <= '0;
                            state    <= WAIT_CONT;
                        end else begin
                            tile_row <= tile_row + 1'b1;
                        end
                    end
                end
                WAIT_CONT: begin
                    // frame_row already points past the tile just issued
                    if (load_continue) begin
                        state <= (frame_row == frame_rows) ? IDLE : ISSUE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Channel-major row index maps straight onto the row address
    assign req_valid = (state == ISSUE);
    assign busy      = (state != IDLE);
    assign req_addr  = frame_row << ix_q;
    assign req_len   = row_len_t'(1) << ix_q;

endmodule

`default_nettype wire

// ==== design/tile_buffer_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_buffer_writer import tiling_pkg::*; #(
    parameter int BUF_NUM        = BUF_NUM_DEFAULT,
    parameter int BUF_DEPTH_2POW = 6
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       load_continue,
    pixel_stream_if.sink              in,
    output logic                      tile_loaded,
    input  wire [$clog2(BUF_NUM)-1:0] rd_col,
    input  wire [BUF_DEPTH_2POW-1:0]  rd_addr,
    output pixel_t                    rd_data
);

    localparam int COL_W = $clog2(BUF_NUM);

    logic [BUF_DEPTH_2POW-1:0] pix_cnt;
    logic [COL_W-1:0]          col_cnt;
    logic [COL_W-1:0]          rd_col_q;
    logic                      accept;
    pixel_t                    col_data [BUF_NUM];

    // Stream stalls while the core owns the buffers
    assign in.ready = !tile_loaded;
    assign accept   = in.valid && in.ready;

    //////////////////////////////
    // Write position tracking
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt     <= '0;
            col_cnt     <= '0;
            tile_loaded <= 1'b0;
        end else begin
            if (load_continue) begin
                tile_loaded <= 1'b0;
            end
            if (accept) begin
                if (in.last) begin
                    pix_cnt <= '0;
                    // Completed row moves on to the next column
                    if (col_cnt == COL_W'(BUF_NUM - 1)) begin
                        col_cnt     <= '0;
                        tile_loaded <= 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Column buffers
    //////////////////////////////

    for (genvar k = 0; k < BUF_NUM; k++) begin : g_col
        column_line_buf #(
            .BUF_DEPTH_2POW(BUF_DEPTH_2POW)
        ) u_buf (
            .clk     (clk),
            .wr_en   (accept && (col_cnt == COL_W'(k))),
            .wr_addr (pix_cnt),
            .wr_data (in.data),
            .rd_addr (rd_addr),
            .rd_data (col_data[k])
        );
    end

    // Select follows the buffers' read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_col_q <= '0;
        end else begin
            rd_col_q <= rd_col;
        end
    end

    assign rd_data = col_data[rd_col_q];

endmodule

`default_nettype wire

// ==== design/load_tiling_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_tiling_top import tiling_pkg::*; #(
    parameter int BUF_NUM        = BUF_NUM_DEFAULT,
    parameter int BUF_DEPTH_2POW = 6,
    parameter int FIFO_DEPTH     = 8
) (
    input  wire                       clk,
    input  wire                       rst_n,
    // Frame control
    input  wire                       start,
    input  wire pow2_t                ix_2pow,
    input  wire pow2_t                iy_2pow,
    input  wire pow2_t                nif_2pow,
    input  wire                       load_continue,
    output logic                      busy,
    output logic                      tile_loaded,
    // DDR request port
    output logic                      req_valid,
    input  wire                       req_ready,
    output ddr_addr_t                 req_addr,
    output row_len_t                  req_len,
    // DDR load data port
    input  wire                       load_valid,
    output logic                      load_ready,
    input  wire pixel_t               load_data,
    input  wire                       load_last,
    // Conv core read port
    input  wire [$clog2(BUF_NUM)-1:0] rd_col,
    input  wire [BUF_DEPTH_2POW-1:0]  rd_addr,
    output pixel_t                    rd_data
);

    //////////////////////////////
    // Request side
    //////////////////////////////

    load_req_gen #(
        .BUF_NUM(BUF_NUM)
    ) u_req_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .ix_2pow       (ix_2pow),
        .iy_2pow       (iy_2pow),
        .nif_2pow      (nif_2pow),
        .load_continue (load_continue),
        .req_ready     (req_ready),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_len       (req_len),
        .busy          (busy)
    );

    //////////////////////////////
    // Data side
    //////////////////////////////

    pixel_stream_if pix_if ();

    load_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_data  (load_data),
        .load_last  (load_last),
        .load_ready (load_ready),
        .out        (pix_if)
    );

    tile_buffer_writer #(
        .BUF_NUM        (BUF_NUM),
        .BUF_DEPTH_2POW (BUF_DEPTH_2POW)
    ) u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_continue (load_continue),
        .in            (pix_if),
        .tile_loaded   (tile_loaded),
        .rd_col        (rd_col),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

// ==== verif/load_tiling_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_tiling_tb import tiling_pkg::*; ();

    localparam int BUF_NUM         = BUF_NUM_DEFAULT;
    localparam int BUF_DEPTH_2POW  = 6;
    localparam int FIFO_DEPTH      = 8;
    localparam int COL_W           = $clog2(BUF_NUM);
    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 5;
    // Largest frame here is 8 rows of 16 pixels
    localparam int MAX_FRAME_BEATS = 128;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    pow2_t                     ix_2pow;
    pow2_t                     iy_2pow;
    pow2_t                     nif_2pow;
    logic                      load_continue;
    logic                      busy;
    logic                      tile_loaded;
    logic                      req_valid;
    logic                      req_ready;
    ddr_addr_t                 req_addr;
    row_len_t                  req_len;
    logic                      load_valid;
    logic                      load_ready;
    pixel_t                    load_data;
    logic                      load_last;
    logic [COL_W-1:0]          rd_col;
    logic [BUF_DEPTH_2POW-1:0] rd_addr;
    pixel_t                    rd_data;

    integer    seed;
    logic      stress;
    ddr_addr_t req_log [$];
    row_len_t  len_log [$];
    ddr_addr_t rows_addr [$];
    row_len_t  rows_len [$];
    int        beat;
    logic      held;
    ddr_addr_t held_addr;
    row_len_t  held_len;
    logic [31:0] rnd;

    load_tiling_top #(
        .BUF_NUM        (BUF_NUM),
        .BUF_DEPTH_2POW (BUF_DEPTH_2POW),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) DUT (
        .clk (clk), .rst_n (rst_n), .start (start),
        .ix_2pow (ix_2pow), .iy_2pow (iy_2pow), .nif_2pow (nif_2pow),
        .load_continue (load_continue), .busy (busy), .tile_loaded (tile_loaded),
        .req_valid (req_valid), .req_ready (req_ready),
        .req_addr (req_addr), .req_len (req_len),
        .load_valid (load_valid), .load_ready (load_ready),
        .load_data (load_data), .load_last (load_last),
        .rd_col (rd_col), .rd_addr (rd_addr), .rd_data (rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s = %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Check failed");
        end
    endtask

    // Memory content rule of the DDR model
    function automatic pixel_t pixel_of(input ddr_addr_t addr);
        ddr_addr_t p;
        p = addr * 3 + 1;
        return p[15:0];
    endfunction

    //////////////////////////////
    // DDR model
    //////////////////////////////

    always begin : ddr_responder
        @(posedge clk);
        if (held) begin
            check_value("req_valid held", req_valid, 1'b1);
            check_value("req_addr held", req_addr, held_addr);
            check_value("req_len held", req_len, held_len);
        end
        held      = req_valid && !req_ready;
        held_addr = req_addr;
        held_len  = req_len;
        if (req_valid && req_ready) begin
            req_log.push_back(req_addr);
            len_log.push_back(req_len);
            rows_addr.push_back(req_addr);
            rows_len.push_back(req_len);
        end
        if (load_valid && load_ready) begin
            if (load_last) begin
                rows_addr.delete(0);
                rows_len.delete(0);
                beat = 0;
            end else begin
                beat++;
            end
        end
        #1;
        rnd = $random(seed);
        req_ready = stress ? rnd[0] : 1'b1;
        if (rows_addr.size() > 0 && !(stress && rnd[1])) begin
            load_valid = 1'b1;
            load_data  = pixel_of(rows_addr[0] + beat);
            load_last  = (beat == rows_len[0] - 1);
        end else begin
            load_valid = 1'b0;
        end
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state();
        check_value("req_valid", req_valid, 1'b0);
        check_value("busy", busy, 1'b0);
        check_value("tile_loaded", tile_loaded, 1'b0);
        check_value("load_ready", load_ready, 1'b1);
    endtask

    // Loads one frame tile by tile and checks requests and buffer contents
    task automatic run_frame(input pow2_t ix, input pow2_t iy, input pow2_t nif);
        int        rows;
        int        row_len;
        int        t;
        int        k;
        int        a;
        int        r;
        ddr_addr_t exp_addr;
        rows    = 1 << (nif + iy);
        row_len = 1 << ix;
        ix_2pow  = ix;
        iy_2pow  = iy;
        nif_2pow = nif;
        start    = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        for (t = 0; t < rows / BUF_NUM; t++) begin
            while (!tile_loaded) begin
                @(posedge clk);
                #1;
            end
            check_value("request count", req_log.size(), BUF_NUM);
            for (k = 0; k < BUF_NUM; k++) begin
                r = t * BUF_NUM + k;
                // Channel r / 2^iy, row r mod 2^iy
                exp_addr = (((r >> iy) << iy) + (r & ((1 << iy) - 1))) << ix;
                check_value("req_addr", req_log.pop_front(), exp_addr);
                check_value("req_len", len_log.pop_front(), row_len);
                for (a = 0; a < row_len; a++) begin
                    rd_col  = k[COL_W-1:0];
                    rd_addr = a[BUF_DEPTH_2POW-1:0];
                    @(posedge clk);
                    #1;
                    check_value("rd_data", rd_data, pixel_of(exp_addr + a));
                end
            end
            // Nothing may be fetched while the core owns the buffers
            check_value("request while paused", req_log.size(), 0);
            check_value("tile_loaded", tile_loaded, 1'b1);
            load_continue = 1'b1;
            @(posedge clk);
            #1;
            load_continue = 1'b0;
            check_value("tile_loaded", tile_loaded, 1'b0);
            check_value("busy", busy, (t != rows / BUF_NUM - 1));
        end
        repeat (4) @(posedge clk);
        #1;
        check_value("request after frame", req_log.size(), 0);
        check_value("busy", busy, 1'b0);
    endtask

    initial begin : watchdog
        #(NUM_TESTS * MAX_FRAME_BEATS * CLK_PERIOD * 4);
        $display("Run did not finish in time");
        $display("Finished with errors");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        seed          = 32'h46e3015b;
        clk           = 1'b0;
        rst_n         = 1'b0;
        start         = 1'b0;
        ix_2pow       = '0;
        iy_2pow       = '0;
        nif_2pow      = '0;
        load_continue = 1'b0;
        req_ready     = 1'b0;
        load_valid    = 1'b0;
        load_data     = '0;
        load_last     = 1'b0;
        rd_col        = '0;
        rd_addr       = '0;
        stress        = 1'b0;
        beat          = 0;
        held          = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        run_frame(4'd3, 4'd2, 4'd1);
        // Same frame with DDR stalls and gaps
        stress = 1'b1;
        run_frame(4'd3, 4'd2, 4'd1);
        stress = 1'b0;
        run_frame(4'd4, 4'd1, 4'd1);
        run_frame(4'd4, 4'd2, 4'd1);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/tiling_pkg.sv
design/pixel_stream_if.sv
design/column_line_buf.sv
design/load_fifo.sv
design/load_req_gen.sv
design/tile_buffer_writer.sv
design/load_tiling_top.sv
verif/load_tiling_tb.sv
